/* cacheTop.f */
rtl/cachePkg.sv
rtl/cacheTagArray.sv
rtl/cacheDataArray.sv
rtl/mainMemory.sv
rtl/cacheFillCtrl.sv
rtl/cacheTop.sv
sim/cacheTop_assert.sv
sim/cacheTopTb.sv

/* rtl/cacheDataArray.sv */
`default_nettype none

module cacheDataArray
	import cachePkg::*;
(
	input wire logic clk,
	input wire logic rst,
	// single port, read or write per cycle
	input wire dataCmdT cmd,
	// registered read return
	output logic respValid,
	output logic [WordWidth-1:0] respData
);

	// line by word storage
	logic [WordWidth-1:0] mem [NumLines][WordsPerLine];

	////////////////////////////////////////
	// write port
	////////////////////////////////////////

	// fill returns and write hits both land here
	always_ff @(posedge clk) begin
		if (cmd.wrEn) begin
			mem[cmd.index][cmd.wordSel] <= cmd.data;
		end
	end

	////////////////////////////////////////
	// read port
	////////////////////////////////////////

	// data one cycle after the read command
	always_ff @(posedge clk) begin
		if (cmd.rdEn) begin
			respData <= mem[cmd.index][cmd.wordSel];
		end
	end

	// flag is a one-cycle pulse per read command
	always_ff @(posedge clk) begin
		if (rst) begin
			respValid <= 1'b0;
		end else begin
			respValid <= cmd.rdEn;
		end
	end

endmodule

`default_nettype wire

/* rtl/cacheFillCtrl.sv */
`default_nettype none

module cacheFillCtrl
	import cachePkg::*;
(
	input wire logic clk,
	input wire logic rst,
	// requester handshake
	input wire logic reqValid,
	input wire cacheReqT req,
	output logic reqReady,
	// tag array
	input wire logic hit,
	output logic tagWrite,
	// data array and memory sides
	output dataCmdT dataCmd,
	output memCmdT memCmd,
	input wire memRespT memResp
);

	fillStateT state;
	fillStateT stateNext;

	// word of the line to request next
	logic [WordSelWidth-1:0] issueCnt;
	// word of the line the next return belongs to
	logic [WordSelWidth-1:0] retCnt;

	logic [IndexWidth-1:0] reqIndex;
	logic [WordSelWidth-1:0] reqWordSel;
	logic readMiss;
	logic accept;
	logic lastIssue;
	logic lastReturn;

	////////////////////////////////////////
	// request decode and handshake
	////////////////////////////////////////

	assign reqIndex = req.addr[TagLsb-1:IndexLsb];
	assign reqWordSel = req.addr[IndexLsb-1:WordSelLsb];

	// a read miss is held back until its line is in place
	assign readMiss = reqValid && !req.write && !hit;
	assign reqReady = (state == FillIdle) && !readMiss;
	assign accept = reqValid && reqReady;

	assign lastIssue = (issueCnt == WordSelWidth'(WordsPerLine - 1));
	assign lastReturn = memResp.valid && (retCnt == WordSelWidth'(WordsPerLine - 1));

	////////////////////////////////////////
	// fill FSM
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FillIdle;
		end else begin
			state <= stateNext;
		end
	end

	always_comb begin
		stateNext = state;
		tagWrite = 1'b0;
		case (state)
			FillIdle: begin
				if (readMiss) begin
					stateNext = FillFetch;
				end
			end
			// one read per cycle until word 7 has gone out
			FillFetch: begin
				if (lastIssue) begin
					stateNext = FillDrain;
				end
			end
			// tag goes in with the last word, held read hits next cycle
			FillDrain: begin
				if (lastReturn) begin
					stateNext = FillIdle;
					tagWrite = 1'b1;
				end
			end
			default: begin
				stateNext = FillIdle;
			end
		endcase
	end

	// both counters wrap back to zero after eight steps
	always_ff @(posedge clk) begin
		if (rst || state == FillIdle) begin
			issueCnt <= '0;
			retCnt <= '0;
		end else begin
			if (state == FillFetch) begin
				issueCnt <= issueCnt + 1'b1;
			end
			if (memResp.valid) begin
				retCnt <= retCnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// command steering
	////////////////////////////////////////

	always_comb begin
		memCmd = '0;
		dataCmd = '0;
		dataCmd.index = reqIndex;
		dataCmd.wordSel = reqWordSel;
		dataCmd.data = req.wdata;
		case (state)
			FillIdle: begin
				// write-through, memory sees every accepted write
				memCmd.en = accept && req.write;
				memCmd.write = req.write;
				memCmd.addr = req.addr;
				memCmd.data = req.wdata;
				// cache copy only updated on a hit, no allocate on write miss
				dataCmd.wrEn = accept && req.write && hit;
				dataCmd.rdEn = accept && !req.write;
			end
			FillFetch: begin
				// line base of the held request plus issue counter
				memCmd.en = 1'b1;
				memCmd.addr = {req.addr[AddrWidth-1:IndexLsb], issueCnt,
					{WordSelLsb{1'b0}}};
			end
			default: begin
				memCmd.en = 1'b0;
			end
		endcase
		// returns may arrive in fetch as well as in drain
		if (state != FillIdle) begin
			dataCmd.wrEn = memResp.valid;
			dataCmd.wordSel = retCnt;
			dataCmd.data = memResp.data;
		end
	end

endmodule

`default_nettype wire

/* rtl/cachePkg.sv */
`default_nettype none

package cachePkg;

	////////////////////////////////////////
	// address layout and geometry
	////////////////////////////////////////

	localparam int AddrWidth = 16;
	localparam int WordWidth = 16;
	localparam int NumLines = 128;
	localparam int WordsPerLine = 8;

	// byte address split: tag | index | word select | byte
	localparam int WordSelWidth = 3;
	localparam int IndexWidth = 7;
	localparam int TagWidth = 5;
	localparam int WordSelLsb = 1;
	localparam int IndexLsb = WordSelLsb + WordSelWidth;
	localparam int TagLsb = IndexLsb + IndexWidth;

	// main memory holds one word per even byte address
	localparam int MemWords = 2 ** (AddrWidth - 1);
	// cycles from read command to returned data
	localparam int MemReadLatency = 4;

	////////////////////////////////////////
	// bundles between blocks
	////////////////////////////////////////

	// requester command, write data ignored on reads
	typedef struct packed {
		logic write;
		logic [AddrWidth-1:0] addr;
		logic [WordWidth-1:0] wdata;
	} cacheReqT;

	// main memory command, one per cycle at most
	typedef struct packed {
		logic en;
		logic write;
		logic [AddrWidth-1:0] addr;
		logic [WordWidth-1:0] data;
	} memCmdT;

	// main memory read return
	typedef struct packed {
		logic valid;
		logic [WordWidth-1:0] data;
	} memRespT;

	// data array port, word addressed by line and word select
	typedef struct packed {
		logic rdEn;
		logic wrEn;
		logic [IndexWidth-1:0] index;
		logic [WordSelWidth-1:0] wordSel;
		logic [WordWidth-1:0] data;
	} dataCmdT;

	// fill FSM: fetch issues and collects, drain only collects
	typedef enum logic [1:0] {
		FillIdle,
		FillFetch,
		FillDrain
	} fillStateT;

endpackage

`default_nettype wire

/* rtl/cacheTagArray.sv */
`default_nettype none

module cacheTagArray
	import cachePkg::*;
(
	input wire logic clk,
	input wire logic rst,
	// address of the request currently held at the front end
	input wire logic [AddrWidth-1:0] lookupAddr,
	// install tag of lookupAddr and mark the line valid
	input wire logic tagWrite,
	output logic hit
);

	// one valid bit per line, kept as a vector so reset is a single clear
	logic [NumLines-1:0] validBits;
	// tag storage, only meaningful where the valid bit is set
	logic [TagWidth-1:0] tagMem [NumLines];

	logic [IndexWidth-1:0] index;
	logic [TagWidth-1:0] tag;

	////////////////////////////////////////
	// address fields
	////////////////////////////////////////

	assign index = lookupAddr[TagLsb-1:IndexLsb];
	assign tag = lookupAddr[AddrWidth-1:TagLsb];

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	// every line starts invalid after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			validBits <= '0;
		end else if (tagWrite) begin
			validBits[index] <= 1'b1;
		end
	end

	// tag written together with the valid bit at the end of a fill
	always_ff @(posedge clk) begin
		if (tagWrite) begin
			tagMem[index] <= tag;
		end
	end

	////////////////////////////////////////
	// lookup
	////////////////////////////////////////

	// same-cycle compare of the indexed line
	assign hit = validBits[index] && (tagMem[index] == tag);

endmodule

`default_nettype wire

/* rtl/cacheTop.sv */
`default_nettype none

module cacheTop
	import cachePkg::*;
(
	input wire logic clk,
	input wire logic rst,
	// requester command, valid/ready
	input wire logic reqValid,
	input wire cacheReqT req,
	output logic reqReady,
	// read response, no back-pressure
	output logic respValid,
	output logic [WordWidth-1:0] respData
);

	logic hit;
	logic tagWrite;
	dataCmdT dataCmd;
	memCmdT memCmd;
	memRespT memResp;

	////////////////////////////////////////
	// control
	////////////////////////////////////////

	// accepts requests and runs line fills on read misses
	cacheFillCtrl fillCtrl0 (
		.clk(clk),
		.rst(rst),
		.reqValid(reqValid),
		.req(req),
		.reqReady(reqReady),
		.hit(hit),
		.tagWrite(tagWrite),
		.dataCmd(dataCmd),
		.memCmd(memCmd),
		.memResp(memResp)
	);

	////////////////////////////////////////
	// cache storage
	////////////////////////////////////////

	// lookup always uses the request at the front end
	cacheTagArray tagArray0 (
		.clk(clk),
		.rst(rst),
		.lookupAddr(req.addr),
		.tagWrite(tagWrite),
		.hit(hit)
	);

	// read data returns straight to the requester
	cacheDataArray dataArray0 (
		.clk(clk),
		.rst(rst),
		.cmd(dataCmd),
		.respValid(respValid),
		.respData(respData)
	);

	////////////////////////////////////////
	// backing store
	////////////////////////////////////////

	mainMemory mainMem0 (
		.clk(clk),
		.rst(rst),
		.cmd(memCmd),
		.resp(memResp)
	);

endmodule

`default_nettype wire

/* rtl/mainMemory.sv */
`default_nettype none

module mainMemory
	import cachePkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire memCmdT cmd,
	// read data exactly MemReadLatency cycles after the command
	output memRespT resp
);

	// word storage, byte address bit 0 dropped
	logic [WordWidth-1:0] mem [MemWords];

	// read delay line, stage 0 loaded from the array
	logic [MemReadLatency-1:0] validPipe;
	logic [WordWidth-1:0] dataPipe [MemReadLatency];

	logic readCmd;

	assign readCmd = cmd.en && !cmd.write;

	////////////////////////////////////////
	// array
	////////////////////////////////////////

	// writes complete at the edge
	always_ff @(posedge clk) begin
		if (cmd.en && cmd.write) begin
			mem[cmd.addr[AddrWidth-1:1]] <= cmd.data;
		end
	end

	////////////////////////////////////////
	// read pipeline
	////////////////////////////////////////

	// data stages carry no reset, the valid bits qualify them
	always_ff @(posedge clk) begin
		dataPipe[0] <= mem[cmd.addr[AddrWidth-1:1]];
		for (int i = 1; i < MemReadLatency; i++) begin
			dataPipe[i] <= dataPipe[i-1];
		end
	end

	// one read per cycle may enter, so reads overlap and stay in order
	always_ff @(posedge clk) begin
		if (rst) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[MemReadLatency-2:0], readCmd};
		end
	end

	// oldest stage drives the return
	assign resp.valid = validPipe[MemReadLatency-1];
	assign resp.data = dataPipe[MemReadLatency-1];

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cacheTopTb -f cacheTop.f -o cacheSim \
	&& ./obj_dir/cacheSim | tee sim.log \
	|| { echo "build or run failed"; exit 1; }
grep -q "RESULT: PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* sim/cacheTopTb.sv */
`default_nettype none

module cacheTopTb
	import cachePkg::*;
();

	localparam int ClkPeriod = 100;
	localparam int DriveDelay = 10;
	// one issue per word, memory latency, turnaround
	localparam int FillBound = WordsPerLine + MemReadLatency + 3;
	localparam int NumOps = 420;
	localparam int WatchdogCycles = NumOps * (FillBound + 2) + 100;
	// random pool over tags 0..3, lines 0..3 and any word
	localparam logic [AddrWidth-1:0] RandMask = 16'h183e;
	// two lines at index 0x45 with tags 0 and 1
	localparam logic [AddrWidth-1:0] LineA = 16'h0450;
	localparam logic [AddrWidth-1:0] LineB = 16'h0c50;

	// accepted read waiting for its response
	typedef struct packed {
		logic [31:0] cycle;
		logic [WordWidth-1:0] data;
	} pendingT;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic reqValid = 1'b0;
	cacheReqT req = '0;
	logic reqReady;
	logic respValid;
	logic [WordWidth-1:0] respData;

	logic [WordWidth-1:0] shadow [logic [AddrWidth-1:0]];
	logic [AddrWidth-1:0] pool [$];
	pendingT pending [$];
	// test that issued each pending read
	string pendingName [$];
	pendingT respEntry;
	string respName;
	logic [31:0] cycleCount = '0;
	logic [31:0] rngState = 32'h288b_c4a0;
	string testName = "reset";
	int dataErrors = 0;
	int handshakeErrors = 0;
	int waits;
	int idx;

	cacheTop dut0 (
		.clk(clk),
		.rst(rst),
		.reqValid(reqValid),
		.req(req),
		.reqReady(reqReady),
		.respValid(respValid),
		.respData(respData)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	////////////////////////////////////////
	// reference and checks
	////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// shadow copy of every accepted write
	function automatic logic [WordWidth-1:0] expectedWord(input logic [AddrWidth-1:0] addr);
		if (shadow.exists(addr)) begin
			return shadow[addr];
		end
		return 'x;
	endfunction

	task automatic checkWord(input string name, input logic [WordWidth-1:0] exp,
		input logic [WordWidth-1:0] act);
		if (act !== exp) begin
			dataErrors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkHandshake(input logic ok, input string what);
		if (ok !== 1'b1) begin
			handshakeErrors++;
			$display("handshake failure in %s: %s", testName, what);
		end
	endtask

	// hold one request until the cache takes it
	task automatic issueRequest(input logic write, input logic [AddrWidth-1:0] addr,
		input logic [WordWidth-1:0] data);
		pendingT entry;
		reqValid = 1'b1;
		req.write = write;
		req.addr = addr;
		req.wdata = data;
		waits = 0;
		@(negedge clk);
		while (!reqReady && waits < FillBound) begin
			@(negedge clk);
			waits++;
		end
		// reqReady high here means transfer at the coming edge
		if (!reqReady) begin
			checkHandshake(1'b0, "request not accepted within the fill bound");
		end else if (write) begin
			shadow[addr] = data;
		end else begin
			entry.cycle = cycleCount + 1;
			entry.data = expectedWord(addr);
			pending.push_back(entry);
			pendingName.push_back(testName);
		end
		@(posedge clk);
		#DriveDelay;
		reqValid = 1'b0;
	endtask

	// responses sampled mid-cycle and matched in order
	always @(negedge clk) begin
		if (!rst && respValid) begin
			if (pending.size() == 0) begin
				checkHandshake(1'b0, "response with no pending read");
			end else begin
				respEntry = pending.pop_front();
				respName = pendingName.pop_front();
				checkHandshake(respEntry.cycle == cycleCount, "response in the wrong cycle");
				checkWord(respName, respEntry.data, respData);
			end
		end else if (!rst && pending.size() != 0) begin
			respEntry = pending[0];
			if (respEntry.cycle <= cycleCount) begin
				checkHandshake(1'b0, "missing response for an accepted read");
				void'(pending.pop_front());
				respName = pendingName.pop_front();
			end
		end
	end

	initial begin
		#(WatchdogCycles * ClkPeriod);
		$display("watchdog expired after %0d cycles, the run did not finish", WatchdogCycles);
		$display("RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial begin
		repeat (5) @(posedge clk);
		#DriveDelay;
		rst = 1'b0;
		checkHandshake(reqReady, "reqReady low after reset");
		checkHandshake(!respValid, "respValid high after reset");
		testName = "line fill on read miss";
		for (int i = 0; i < WordsPerLine; i++) begin
			rngState = xorshift(rngState);
			issueRequest(1'b1, LineA + 16'(2 * i), rngState[15:0]);
			checkHandshake(waits == 0, "write not accepted when presented");
		end
		issueRequest(1'b0, LineA + 16'd6, 16'h0);
		checkHandshake(waits > 0, "read of an empty line did not miss");
		testName = "hits on the filled line";
		for (int i = 0; i < WordsPerLine; i++) begin
			issueRequest(1'b0, LineA + 16'(2 * i), 16'h0);
			checkHandshake(waits == 0, "read of a cached word stalled");
		end
		testName = "write hit then read";
		rngState = xorshift(rngState);
		issueRequest(1'b1, LineA + 16'd4, rngState[31:16]);
		issueRequest(1'b0, LineA + 16'd4, 16'h0);
		checkHandshake(waits == 0, "read after a write hit stalled");
		// write misses leave line A in place
		testName = "refill on tag conflict";
		for (int i = 0; i < WordsPerLine; i++) begin
			rngState = xorshift(rngState);
			issueRequest(1'b1, LineB + 16'(2 * i), rngState[15:0]);
		end
		issueRequest(1'b0, LineA + 16'd2, 16'h0);
		checkHandshake(waits == 0, "write miss disturbed the cached line");
		issueRequest(1'b0, LineB + 16'd2, 16'h0);
		checkHandshake(waits > 0, "read of a new tag did not miss");
		issueRequest(1'b0, LineA, 16'h0);
		checkHandshake(waits > 0, "read of the evicted line did not miss");
		issueRequest(1'b0, LineA + 16'd4, 16'h0);
		testName = "random reads and writes";
		for (int i = 0; i < 64; i++) begin
			rngState = xorshift(rngState);
			pool.push_back(rngState[15:0] & RandMask);
			issueRequest(1'b1, rngState[15:0] & RandMask, rngState[31:16]);
		end
		for (int i = 0; i < 300; i++) begin
			rngState = xorshift(rngState);
			idx = int'(rngState[21:16]);
			issueRequest(rngState[0], pool[idx], rngState[31:16]);
		end
		repeat (3) @(negedge clk);
		$display("errors: data %0d, handshake %0d", dataErrors, handshakeErrors);
		if (dataErrors == 0 && handshakeErrors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/cacheTop_assert.sv */
`default_nettype none

module cacheTopAssert
	import cachePkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic reqValid,
	input wire cacheReqT req,
	input wire logic reqReady,
	input wire logic respValid
);

	logic readAccept;

	// read transfer on the requester port
	assign readAccept = reqValid && reqReady && !req.write;

	// every accepted read answers in the next cycle
	respAfterRead: assert property (@(posedge clk) disable iff (rst)
		readAccept |=> respValid) else $error("no response after an accepted read");

	// and nothing else raises respValid
	respOnlyAfterRead: assert property (@(posedge clk) disable iff (rst)
		respValid |-> $past(readAccept)) else $error("response without a read");

	// requester holds its command under back-pressure
	reqHeld: assert property (@(posedge clk) disable iff (rst)
		(reqValid && !reqReady) |=> $stable(req)) else $error("req changed while stalled");

	readyAfterReset: assert property (@(posedge clk)
		$fell(rst) |-> reqReady) else $error("reqReady low after reset");

endmodule

bind cacheTop cacheTopAssert assert0 (.*);

`default_nettype wire
